//--- source/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Two bits cover the three independent result sources
    localparam int STATUS_WIDTH = 2;

    typedef logic [4:0] reg_addr_t;
    typedef logic [STATUS_WIDTH-1:0] reg_status_t;

    // Same encoding as the funct3 field of RV32I loads
    typedef enum logic [2:0] {
        LOAD_LB  = 3'b000,
        LOAD_LH  = 3'b001,
        LOAD_LW  = 3'b010,
        LOAD_LBU = 3'b100,
        LOAD_LHU = 3'b101
    } load_op_e;

    typedef struct packed {
        reg_addr_t   addr;
        logic [31:0] value;
        reg_status_t reg_status;
        logic        speculative;
    } wb_op_t;

    typedef struct packed {
        reg_addr_t   addr;
        reg_status_t reg_status;
        logic [1:0]  offset;
        load_op_e    op;
    } mem_cmd_t;

    // Picks the addressed byte or halfword out of the word and extends it
    function automatic logic [31:0] align_load(
        input logic [31:0] word,
        input logic [1:0]  offset,
        input load_op_e    op
    );
        logic [31:0] shifted;
        shifted = word >> {offset, 3'b000};
        case (op)
            LOAD_LB:  return {{24{shifted[7]}}, shifted[7:0]};
            LOAD_LH:  return {{16{shifted[15]}}, shifted[15:0]};
            LOAD_LBU: return {24'b0, shifted[7:0]};
            LOAD_LHU: return {16'b0, shifted[15:0]};
            default:  return word;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/result_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module result_fifo #(
    parameter int DEPTH = 4,
    parameter type item_t = logic [31:0]
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output logic  not_empty,
    output item_t head,
    output logic  credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // A push beyond DEPTH would break the credit contract, drop it
    assign do_push   = push && (count != CNT_W'(DEPTH));
    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back to the producer per freed entry
            credit <= do_pop;
        end
    end

endmodule

`default_nettype wire

//--- source/load_join_stage.sv
`timescale 1ns/1ns
`default_nettype none

module load_join_stage #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              mcmd_valid,
    input  wb_pkg::mem_cmd_t  mcmd,
    output logic              mcmd_credit,
    input  logic              mem_rsp_valid,
    input  logic [31:0]       mem_rsp_data,
    input  logic              ld_pop,
    output logic              ld_valid,
    output wb_pkg::wb_op_t    ld_op
);

    wb_pkg::mem_cmd_t cmd_head;
    logic             cmd_ready;
    logic [31:0]      data_head;
    logic             data_ready;

    // Pending load commands, one per issued load
    result_fifo #(
        .DEPTH (DEPTH),
        .item_t(wb_pkg::mem_cmd_t)
    ) cmd_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (mcmd_valid),
        .push_item(mcmd),
        .pop      (ld_pop),
        .not_empty(cmd_ready),
        .head     (cmd_head),
        .credit   (mcmd_credit)
    );

    // Data words arrive in command order, the command credit
    // already reserved a slot here
    result_fifo #(
        .DEPTH (DEPTH),
        .item_t(logic [31:0])
    ) data_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (mem_rsp_valid),
        .push_item(mem_rsp_data),
        .pop      (ld_pop),
        .not_empty(data_ready),
        .head     (data_head),
        .credit   ()
    );

    // A load is complete once both halves are present
    assign ld_valid = cmd_ready && data_ready;

    always_comb begin
        ld_op.addr        = cmd_head.addr;
        ld_op.value       = wb_pkg::align_load(data_head, cmd_head.offset, cmd_head.op);
        ld_op.reg_status  = cmd_head.reg_status;
        ld_op.speculative = 1'b0;
    end

endmodule

`default_nettype wire

//--- source/writeback_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           exe_ready,
    input  wb_pkg::wb_op_t exe_head,
    input  logic           sys_ready,
    input  wb_pkg::wb_op_t sys_head,
    input  logic           ld_valid,
    input  wb_pkg::wb_op_t ld_op,
    output logic           exe_pop,
    output logic           sys_pop,
    output logic           ld_pop,
    output logic           wb_valid,
    output wb_pkg::wb_op_t wb_op
);

    typedef enum logic [1:0] {
        SRC_EXE = 2'd0,
        SRC_LD  = 2'd1,
        SRC_SYS = 2'd2
    } src_e;

    // Expected tag per architectural register
    wb_pkg::reg_status_t status_table [32];

    logic              sweeping;
    wb_pkg::reg_addr_t sweep_addr;
    src_e              rr_ptr;

    logic           exe_ok;
    logic           ld_ok;
    logic           sys_ok;
    logic           take_exe;
    logic           take_ld;
    logic           take_sys;
    logic           take_any;
    wb_pkg::wb_op_t win_op;

    // Three read ports, one per candidate
    assign exe_ok = !sweeping && exe_ready
                    && (status_table[exe_head.addr] == exe_head.reg_status);
    assign ld_ok  = !sweeping && ld_valid
                    && (status_table[ld_op.addr] == ld_op.reg_status);
    assign sys_ok = !sweeping && sys_ready
                    && (status_table[sys_head.addr] == sys_head.reg_status);

    always_comb begin
        take_exe = 1'b0;
        take_ld  = 1'b0;
        take_sys = 1'b0;
        case (rr_ptr)
            SRC_EXE: take_exe = exe_ok;
            SRC_LD:  take_ld  = ld_ok;
            default: take_sys = sys_ok;
        endcase
        // Source under the pointer has nothing to give
        if (!(take_exe || take_ld || take_sys)) begin
            if (exe_ok) begin
                take_exe = 1'b1;
            end else if (ld_ok) begin
                take_ld = 1'b1;
            end else if (sys_ok) begin
                take_sys = 1'b1;
            end
        end
    end

    assign take_any = take_exe || take_ld || take_sys;

    always_comb begin
        if (take_exe) begin
            win_op = exe_head;
        end else if (take_ld) begin
            win_op = ld_op;
        end else begin
            win_op = sys_head;
        end
    end

    assign exe_pop = take_exe;
    assign ld_pop  = take_ld;
    assign sys_pop = take_sys;

    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping   <= 1'b1;
            sweep_addr <= '0;
            rr_ptr     <= SRC_EXE;
            wb_valid   <= 1'b0;
        end else begin
            if (sweeping) begin
                sweep_addr <= sweep_addr + 1'b1;
                if (sweep_addr == 5'd31) begin
                    sweeping <= 1'b0;
                end
            end
            wb_valid <= take_any;
            if (take_exe) begin
                rr_ptr <= SRC_LD;
            end else if (take_ld) begin
                rr_ptr <= SRC_SYS;
            end else if (take_sys) begin
                rr_ptr <= SRC_EXE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_any) begin
            wb_op <= win_op;
        end
    end

    // Sweep clears one entry per cycle, afterwards each taken result
    // advances the tag its register expects next
    always_ff @(posedge clk) begin
        if (sweeping) begin
            status_table[sweep_addr] <= '0;
        end else if (take_any) begin
            status_table[win_op.addr] <= win_op.reg_status + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/writeback_top.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_top #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              exe_valid,
    input  wb_pkg::wb_op_t    exe_op,
    output logic              exe_credit,
    input  logic              sys_valid,
    input  wb_pkg::wb_op_t    sys_op,
    output logic              sys_credit,
    input  logic              mcmd_valid,
    input  wb_pkg::mem_cmd_t  mcmd,
    output logic              mcmd_credit,
    input  logic              mem_rsp_valid,
    input  logic [31:0]       mem_rsp_data,
    output logic              wb_valid,
    output wb_pkg::wb_op_t    wb_op
);

    logic           exe_ready;
    logic           exe_pop;
    wb_pkg::wb_op_t exe_head;
    logic           sys_ready;
    logic           sys_pop;
    wb_pkg::wb_op_t sys_head;
    logic           ld_valid;
    logic           ld_pop;
    wb_pkg::wb_op_t ld_op;

    result_fifo #(.DEPTH(DEPTH), .item_t(wb_pkg::wb_op_t)) exe_fifo (
        .clk(clk), .rst(rst),
        .push(exe_valid), .push_item(exe_op),
        .pop(exe_pop), .not_empty(exe_ready), .head(exe_head),
        .credit(exe_credit)
    );

    result_fifo #(.DEPTH(DEPTH), .item_t(wb_pkg::wb_op_t)) sys_fifo (
        .clk(clk), .rst(rst),
        .push(sys_valid), .push_item(sys_op),
        .pop(sys_pop), .not_empty(sys_ready), .head(sys_head),
        .credit(sys_credit)
    );

    load_join_stage #(.DEPTH(DEPTH)) load_join (
        .clk(clk), .rst(rst),
        .mcmd_valid(mcmd_valid), .mcmd(mcmd), .mcmd_credit(mcmd_credit),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
        .ld_pop(ld_pop), .ld_valid(ld_valid), .ld_op(ld_op)
    );

    writeback_arbiter arbiter (
        .clk(clk), .rst(rst),
        .exe_ready(exe_ready), .exe_head(exe_head),
        .sys_ready(sys_ready), .sys_head(sys_head),
        .ld_valid(ld_valid), .ld_op(ld_op),
        .exe_pop(exe_pop), .sys_pop(sys_pop), .ld_pop(ld_pop),
        .wb_valid(wb_valid), .wb_op(wb_op)
    );

endmodule

`default_nettype wire

//--- test/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Reset held over three rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- test/writeback_tb.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_tb;

    localparam int DEPTH = 4;
    localparam int MAX_ROWS = 64;
    localparam int SRC_EXE = 0;
    localparam int SRC_LD = 1;
    localparam int SRC_SYS = 2;

    typedef logic [15:0] count_t;

    logic              clk;
    logic              rst;
    logic              exe_valid;
    wb_pkg::wb_op_t    exe_op;
    logic              exe_credit;
    logic              sys_valid;
    wb_pkg::wb_op_t    sys_op;
    logic              sys_credit;
    logic              mcmd_valid;
    wb_pkg::mem_cmd_t  mcmd;
    logic              mcmd_credit;
    logic              mem_rsp_valid;
    logic [31:0]       mem_rsp_data;
    logic              wb_valid;
    wb_pkg::wb_op_t    wb_op;

    // Stimulus and expected table, one column per array
    int                  row_src [MAX_ROWS];
    wb_pkg::reg_addr_t   row_addr [MAX_ROWS];
    wb_pkg::reg_status_t row_tag [MAX_ROWS];
    logic [31:0]         row_word [MAX_ROWS];
    logic [1:0]          row_offset [MAX_ROWS];
    wb_pkg::load_op_e    row_op [MAX_ROWS];
    logic                row_spec [MAX_ROWS];
    int                  row_ord [MAX_ROWS];
    wb_pkg::wb_op_t      row_exp [MAX_ROWS];
    bit                  row_done [MAX_ROWS];
    int                  n_rows = 0;
    bit                  table_ready = 1'b0;

    int pulses [3];
    int sent [3];
    int next_ord [32];
    int out_count = 0;
    int post_rst = 0;
    int fair_seen = 0;
    int fair_last1 = -1;
    int fair_last2 = -1;

    clock_gen clocks (
        .clk(clk),
        .rst(rst)
    );

    writeback_top #(.DEPTH(DEPTH)) uut (
        .clk(clk), .rst(rst),
        .exe_valid(exe_valid), .exe_op(exe_op), .exe_credit(exe_credit),
        .sys_valid(sys_valid), .sys_op(sys_op), .sys_credit(sys_credit),
        .mcmd_valid(mcmd_valid), .mcmd(mcmd), .mcmd_credit(mcmd_credit),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
        .wb_valid(wb_valid), .wb_op(wb_op)
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_op(input string name, input wb_pkg::wb_op_t got,
                              input wb_pkg::wb_op_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Byte lane or halfword lane of the memory word, then extension
    function automatic logic [31:0] load_value(input logic [31:0] word, input int offset,
                                               input wb_pkg::load_op_e op);
        logic [7:0]  b;
        logic [15:0] h;
        case (offset)
            1:       b = word[15:8];
            2:       b = word[23:16];
            3:       b = word[31:24];
            default: b = word[7:0];
        endcase
        h = offset[1] ? word[31:16] : word[15:0];
        case (op)
            wb_pkg::LOAD_LB:  return 32'($signed(b));
            wb_pkg::LOAD_LBU: return {24'h0, b};
            wb_pkg::LOAD_LH:  return 32'($signed(h));
            wb_pkg::LOAD_LHU: return {16'h0, h};
            default:          return word;
        endcase
    endfunction

    // Loads take the aligned word with speculative clear, others pass through
    task automatic add_row(input int src, input int addr, input int tag,
                           input logic [31:0] word, input int offset,
                           input wb_pkg::load_op_e op, input logic spec, input int ord);
        row_src[n_rows]    = src;
        row_addr[n_rows]   = 5'(addr);
        row_tag[n_rows]    = 2'(tag);
        row_word[n_rows]   = word;
        row_offset[n_rows] = 2'(offset);
        row_op[n_rows]     = op;
        row_spec[n_rows]   = spec;
        row_ord[n_rows]    = ord;
        row_done[n_rows]   = 1'b0;
        row_exp[n_rows].addr       = 5'(addr);
        row_exp[n_rows].reg_status = 2'(tag);
        if (src == SRC_LD) begin
            row_exp[n_rows].value       = load_value(word, offset, op);
            row_exp[n_rows].speculative = 1'b0;
        end else begin
            row_exp[n_rows].value       = word;
            row_exp[n_rows].speculative = spec;
        end
        n_rows++;
    endtask

    function automatic logic [31:0] word_for(input int k);
        return 32'h8a7f_f00e ^ (32'(k) * 32'h1357_9bdf);
    endfunction

    function automatic int next_of(input int src, input int from, input int hi);
        int i;
        i = from;
        while (i < hi && row_src[i] != src) begin
            i++;
        end
        return i;
    endfunction

    // Match an output against the oldest pending row of its register
    task automatic check_output(input wb_pkg::wb_op_t got);
        int found;
        int src;
        found = -1;
        for (int i = 0; i < n_rows; i++) begin
            if (found < 0 && !row_done[i] && row_addr[i] == got.addr
                    && row_ord[i] == next_ord[got.addr]) begin
                found = i;
            end
        end
        if (found < 0) begin
            stop_on_error($sformatf("Output to register %0d matches no pending row",
                                    got.addr));
        end
        compare_op("wb_op", got, row_exp[found]);
        row_done[found] = 1'b1;
        next_ord[got.addr]++;
        out_count++;
        // Registers 14 to 22 belong to the fairness rows
        if (got.addr >= 14 && got.addr <= 22) begin
            src = row_src[found];
            fair_seen++;
            if (fair_seen >= 3 && (src == fair_last1 || src == fair_last2
                                   || fair_last1 == fair_last2)) begin
                stop_on_error("A source was skipped within three consecutive outputs");
            end
            fair_last2 = fair_last1;
            fair_last1 = src;
        end
    endtask

    // Outputs and credits are sampled on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            post_rst = 0;
        end else begin
            post_rst++;
            if (post_rst <= 33 && (wb_valid || exe_credit || sys_credit || mcmd_credit)) begin
                stop_on_error("Output or credit activity during the status sweep");
            end
            if (exe_credit) pulses[SRC_EXE]++;
            if (mcmd_credit) pulses[SRC_LD]++;
            if (sys_credit) pulses[SRC_SYS]++;
            if (wb_valid) begin
                check_output(wb_op);
            end
        end
    end

    // Drive rows lo..hi-1 on falling edges, gated by credits
    task automatic drive_rows(input int lo, input int hi, input bit fair);
        int          idx [3];
        int          gap [3];
        logic [31:0] mq_data [$];
        int          mq_due [$];
        int          cyc;
        int          r;
        cyc = 0;
        for (int s = 0; s < 3; s++) begin
            idx[s] = next_of(s, lo, hi);
            gap[s] = 0;
        end
        while (idx[0] < hi || idx[1] < hi || idx[2] < hi || mq_data.size() > 0) begin
            @(negedge clk);
            cyc++;
            exe_valid     = 1'b0;
            sys_valid     = 1'b0;
            mcmd_valid    = 1'b0;
            mem_rsp_valid = 1'b0;
            for (int s = 0; s < 3; s++) begin
                if (idx[s] < hi) begin
                    if (gap[s] > 0) begin
                        gap[s]--;
                    end else if (DEPTH + pulses[s] - sent[s] > 0) begin
                        r = idx[s];
                        if (s == SRC_LD) begin
                            mcmd_valid      = 1'b1;
                            mcmd.addr       = row_addr[r];
                            mcmd.reg_status = row_tag[r];
                            mcmd.offset     = row_offset[r];
                            mcmd.op         = row_op[r];
                            mq_data.push_back(row_word[r]);
                            mq_due.push_back(fair ? cyc : cyc + int'($urandom % 4));
                        end else if (s == SRC_EXE) begin
                            exe_valid          = 1'b1;
                            exe_op.addr        = row_addr[r];
                            exe_op.value       = row_word[r];
                            exe_op.reg_status  = row_tag[r];
                            exe_op.speculative = row_spec[r];
                        end else begin
                            sys_valid          = 1'b1;
                            sys_op.addr        = row_addr[r];
                            sys_op.value       = row_word[r];
                            sys_op.reg_status  = row_tag[r];
                            sys_op.speculative = row_spec[r];
                        end
                        sent[s]++;
                        idx[s] = next_of(s, r + 1, hi);
                        gap[s] = fair ? 0 : int'($urandom % 3);
                    end
                end
            end
            // Memory words follow their commands in order
            if (mq_data.size() > 0 && mq_due[0] <= cyc) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = mq_data.pop_front();
                void'(mq_due.pop_front());
            end
        end
        @(negedge clk);
        exe_valid     = 1'b0;
        sys_valid     = 1'b0;
        mcmd_valid    = 1'b0;
        mem_rsp_valid = 1'b0;
    endtask

    task automatic wait_outputs(input int target);
        while (out_count < target) begin
            @(negedge clk);
        end
    endtask

    initial begin
        wait (table_ready);
        repeat (40 * n_rows + 32) @(posedge clk);
        $display("Watchdog expired before all rows were written back");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        int     seed_dummy;
        int     p1_end;
        int     p2_end;
        int     k;
        int     expect_rows [3];
        seed_dummy    = $urandom(56657);
        exe_valid     = 1'b0;
        exe_op        = '0;
        sys_valid     = 1'b0;
        sys_op        = '0;
        mcmd_valid    = 1'b0;
        mcmd          = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        for (int i = 0; i < 32; i++) next_ord[i] = 0;
        for (int s = 0; s < 3; s++) begin
            pulses[s] = 0;
            sent[s]   = 0;
        end

        // Every load kind at every legal offset, plus plain results
        k = 0;
        for (int o = 0; o < 4; o++) begin
            add_row(SRC_LD, 1 + k, 0, word_for(k), o, wb_pkg::LOAD_LB, 1'b0, 0);
            k++;
            add_row(SRC_LD, 1 + k, 0, word_for(k), o, wb_pkg::LOAD_LBU, 1'b0, 0);
            k++;
        end
        for (int o = 0; o < 4; o += 2) begin
            add_row(SRC_LD, 1 + k, 0, word_for(k), o, wb_pkg::LOAD_LH, 1'b0, 0);
            k++;
            add_row(SRC_LD, 1 + k, 0, word_for(k), o, wb_pkg::LOAD_LHU, 1'b0, 0);
            k++;
        end
        add_row(SRC_LD, 1 + k, 0, word_for(k), 0, wb_pkg::LOAD_LW, 1'b1, 0);
        for (int i = 0; i < 3; i++) begin
            add_row(SRC_EXE, 23 + i, 0, word_for(20 + i), 0, wb_pkg::LOAD_LW, 1'(i), 0);
            add_row(SRC_SYS, 26 + i, 0, word_for(30 + i), 0, wb_pkg::LOAD_LW, 1'(i + 1), 0);
        end
        p1_end = n_rows;

        // One register, tags pushed out of order across sources
        add_row(SRC_EXE, 30, 1, 32'h1111_0001, 0, wb_pkg::LOAD_LW, 1'b0, 1);
        add_row(SRC_LD, 30, 2, 32'hf00d_8182, 2, wb_pkg::LOAD_LH, 1'b0, 2);
        add_row(SRC_EXE, 30, 3, 32'h3333_0003, 0, wb_pkg::LOAD_LW, 1'b1, 3);
        add_row(SRC_LD, 30, 0, 32'h7e80_1234, 1, wb_pkg::LOAD_LBU, 1'b0, 4);
        add_row(SRC_SYS, 30, 0, 32'h0000_0bad, 0, wb_pkg::LOAD_LW, 1'b0, 0);
        p2_end = n_rows;

        // Fairness, each source on its own registers
        for (int t = 0; t < 2; t++) begin
            for (int i = 0; i < 3; i++) begin
                add_row(SRC_EXE, 14 + i, t, word_for(40 + i + 3 * t), 0,
                        wb_pkg::LOAD_LW, 1'b0, t);
                add_row(SRC_LD, 17 + i, t, word_for(50 + i + 3 * t), i,
                        wb_pkg::LOAD_LB, 1'b0, t);
                add_row(SRC_SYS, 20 + i, t, word_for(60 + i + 3 * t), 0,
                        wb_pkg::LOAD_LW, 1'b1, t);
            end
        end
        table_ready = 1'b1;

        // Reset drops on a falling edge, so look for it on rising edges
        @(negedge clk);
        while (rst) @(posedge clk);

        drive_rows(0, p1_end, 1'b0);
        wait_outputs(p1_end);
        drive_rows(p1_end, p2_end, 1'b0);
        wait_outputs(p2_end);
        drive_rows(p2_end, n_rows, 1'b1);
        wait_outputs(n_rows);
        repeat (4) @(negedge clk);

        for (int s = 0; s < 3; s++) expect_rows[s] = 0;
        for (int i = 0; i < n_rows; i++) expect_rows[row_src[i]]++;
        compare_count("exe_credit total", count_t'(pulses[SRC_EXE]),
                      count_t'(expect_rows[SRC_EXE]));
        compare_count("mcmd_credit total", count_t'(pulses[SRC_LD]),
                      count_t'(expect_rows[SRC_LD]));
        compare_count("sys_credit total", count_t'(pulses[SRC_SYS]),
                      count_t'(expect_rows[SRC_SYS]));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
source/wb_pkg.sv
source/result_fifo.sv
source/load_join_stage.sv
source/writeback_arbiter.sv
source/writeback_top.sv
test/clock_gen.sv
test/writeback_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module writeback_tb -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vwriteback_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
